// ==== files.f ====
hdl/i2c_regs_pkg.sv
hdl/i2c_reg_port.sv
hdl/byte_fifo.sv
hdl/apb_reg_port.sv
hdl/i2c_periph_regs.sv
sim/i2c_periph_regs_sva.sv
sim/tb_i2c_periph_regs.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the i2c register block testbench with verilator

cd "$(dirname "$0")" || exit 1

obj=obj_dir
log=sim.log

verilator --binary --assert --timing -Wno-fatal -f files.f \
  --top-module tb_i2c_periph_regs -Mdir "$obj" -o vsim
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

# let assertion errors be counted instead of stopping at the first
"./$obj/vsim" +verilator+error+limit+1000 > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "sim failed" "$log"; then
  echo "failure reported, see $log"
  exit 1
fi
exit 0

// ==== sim/tb_i2c_periph_regs.sv ====
module tb_i2c_periph_regs
  import i2c_regs_pkg::*;
();
  timeunit 1ns;
  timeprecision 1ps;

  typedef enum int {k_hwr, k_hrd, k_hrd_done, k_iwr, k_ird, k_irq, k_cfg} kind_e;

  localparam int max_rows = 128;

  logic                   clk;
  logic                   rst;
  logic [host_addr_w-1:0] host_waddr_i;
  logic [host_data_w-1:0] host_wdata_i;
  logic                   host_wr_en_i;
  logic [host_addr_w-1:0] host_raddr_i;
  logic                   host_rd_done_i;
  logic [host_data_w-1:0] host_rdata_o;
  logic [byte_w-1:0]      i2c_addr_i;
  logic [byte_w-1:0]      i2c_wdata_i;
  logic                   i2c_wr_en_i;
  logic [byte_w-1:0]      i2c_rdata_o;
  logic [dev_addr_w-1:0]  dev_addr_o;
  logic                   enable_o;
  logic [byte_w-1:0]      debounce_len_o;
  logic [byte_w-1:0]      scl_delay_len_o;
  logic [byte_w-1:0]      sda_delay_len_o;
  logic                   host_irq_o;

  // stimulus table, one row per step
  string row_name [max_rows];
  kind_e row_kind [max_rows];
  int    row_addr [max_rows];
  int    row_data [max_rows];
  int    row_exp  [max_rows];
  int    n_rows = 0;

  int errors = 0;
  int passes = 0;
  int cycles = 0;
  int timeout_cycles = 0;

  i2c_periph_regs UUT (.*);

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= timeout_cycles) begin
      $display("timeout after %0d cycles, the table did not complete", timeout_cycles);
      $display("sim failed");
      $finish;
    end
  end

  // host registers sit on word addresses
  function automatic int reg_addr(input int idx);
    return idx * 4;
  endfunction

  function automatic int rand_byte();
    return int'($urandom() & 32'hff);
  endfunction

  task automatic add_row(input string name, input kind_e kind, input int addr,
                         input int data, input int exp_val);
    row_name[n_rows] = name;
    row_kind[n_rows] = kind;
    row_addr[n_rows] = addr;
    row_data[n_rows] = data;
    row_exp[n_rows]  = exp_val;
    n_rows++;
  endtask

  task automatic check_word(input string name, input logic [host_data_w-1:0] exp_v,
                            input logic [host_data_w-1:0] act_v);
    if (act_v !== exp_v) begin
      $display("Mismatch %s: expected %h, actual %h", name, exp_v, act_v);
      errors++;
    end else begin
      $display("ok %s: %h", name, act_v);
      passes++;
    end
  endtask

  task automatic check_byte(input string name, input logic [byte_w-1:0] exp_v,
                            input logic [byte_w-1:0] act_v);
    if (act_v !== exp_v) begin
      $display("Mismatch %s: expected %h, actual %h", name, exp_v, act_v);
      errors++;
    end else begin
      $display("ok %s: %h", name, act_v);
      passes++;
    end
  endtask

  task automatic check_bit(input string name, input logic exp_v, input logic act_v);
    if (act_v !== exp_v) begin
      $display("Mismatch %s: expected %b, actual %b", name, exp_v, act_v);
      errors++;
    end else begin
      $display("ok %s: %b", name, act_v);
      passes++;
    end
  endtask

  task automatic build_table();
    int dflt [5];
    int cfg [5];
    int cfg_exp [5];
    int fb [17];
    int mbox;
    dflt = '{'h6f, 0, 20, 20, 8};
    for (int k = 0; k < 5; k++) begin
      add_row($sformatf("reset host reg %0d", k), k_hrd, reg_addr(k), 0, dflt[k]);
      add_row($sformatf("reset i2c reg %0d", k), k_ird, k, 0, dflt[k]);
      add_row($sformatf("reset output %0d", k), k_cfg, k, 0, dflt[k]);
    end
    // config written from the host, dev addr keeps 7 bits, enable 1 bit
    for (int k = 0; k < 5; k++) begin
      cfg[k] = rand_byte();
      cfg_exp[k] = (k == 0) ? (cfg[k] & 'h7f) : (k == 1) ? (cfg[k] & 1) : cfg[k];
      add_row($sformatf("host write reg %0d", k), k_hwr, reg_addr(k), cfg[k], 0);
    end
    for (int k = 0; k < 5; k++) begin
      add_row($sformatf("host read reg %0d", k), k_hrd, reg_addr(k), 0, cfg_exp[k]);
      add_row($sformatf("i2c read reg %0d", k), k_ird, k, 0, cfg_exp[k]);
      add_row($sformatf("output %0d", k), k_cfg, k, 0, cfg_exp[k]);
    end
    add_row("write above range", k_hwr, 'h400, 'h15, 0);
    add_row("read above range", k_hrd, 'h400, 0, 0);
    add_row("dev addr untouched", k_hrd, reg_addr(idx_dev_addr), 0, cfg_exp[0]);
    add_row("i2c read unmapped", k_ird, 'h30, 0, 0);
    // mailbox from i2c to host
    mbox = rand_byte();
    add_row("mbox i2c write", k_iwr, idx_mbox_data, mbox, 0);
    add_row("mbox status set", k_hrd, reg_addr(idx_mbox_status), 0, 1);
    add_row("mbox data read", k_hrd_done, reg_addr(idx_mbox_data), 0, mbox);
    add_row("mbox status clear", k_hrd, reg_addr(idx_mbox_status), 0, 0);
    add_row("mbox i2c status", k_ird, idx_mbox_status, 0, 0);
    // three bytes through the fifo
    for (int k = 0; k < 3; k++) begin
      fb[k] = rand_byte();
      add_row($sformatf("push %0d", k), k_iwr, idx_fifo_wr, fb[k], 0);
    end
    add_row("flags three bytes", k_hrd, reg_addr(idx_fifo_flags), 0, 0);
    for (int k = 0; k < 3; k++) begin
      add_row($sformatf("pop %0d", k), k_hrd_done, reg_addr(idx_fifo_rd), 0, fb[k]);
    end
    add_row("flags drained", k_hrd, reg_addr(idx_fifo_flags), 0, 1);
    add_row("flags i2c side", k_ird, idx_fifo_flags, 0, 1);
    // interrupt, fifo term then mailbox term
    add_row("irq select", k_hwr, reg_addr(idx_irq_select), 'h02, 0);
    add_row("irq enable fifo", k_hwr, reg_addr(idx_irq_enable), 'h2, 0);
    add_row("irq on empty", k_irq, 0, 0, 1);
    fb[0] = rand_byte();
    add_row("irq push", k_iwr, idx_fifo_wr, fb[0], 0);
    add_row("irq off after push", k_irq, 0, 0, 0);
    add_row("irq enable mbox", k_hwr, reg_addr(idx_irq_enable), 'h1, 0);
    add_row("irq mbox idle", k_irq, 0, 0, 0);
    mbox = rand_byte();
    add_row("irq mbox write", k_iwr, idx_mbox_data, mbox, 0);
    add_row("irq on mbox", k_irq, 0, 0, 1);
    add_row("irq mbox read", k_hrd_done, reg_addr(idx_mbox_data), 0, mbox);
    add_row("irq off after read", k_irq, 0, 0, 0);
    add_row("irq drain fifo", k_hrd_done, reg_addr(idx_fifo_rd), 0, fb[0]);
    add_row("irq enable off", k_hwr, reg_addr(idx_irq_enable), 0, 0);
    // overfill, the 17th byte is dropped
    for (int k = 0; k < 17; k++) begin
      fb[k] = rand_byte();
      add_row($sformatf("fill push %0d", k), k_iwr, idx_fifo_wr, fb[k], 0);
    end
    add_row("flags full", k_hrd, reg_addr(idx_fifo_flags), 0, 6);
    for (int k = 0; k < 16; k++) begin
      add_row($sformatf("fill pop %0d", k), k_hrd_done, reg_addr(idx_fifo_rd), 0, fb[k]);
    end
    add_row("flags empty again", k_hrd, reg_addr(idx_fifo_flags), 0, 1);
    add_row("push after drain", k_iwr, idx_fifo_wr, ~fb[16] & 'hff, 0);
    add_row("pop after drain", k_hrd_done, reg_addr(idx_fifo_rd), 0, ~fb[16] & 'hff);
    add_row("flags final", k_hrd, reg_addr(idx_fifo_flags), 0, 1);
  endtask

  task automatic run_row(input int i);
    logic [byte_w-1:0] cfg_val;
    @(posedge clk);
    case (row_kind[i])
      k_hwr: begin
        host_waddr_i <= host_addr_w'(row_addr[i]);
        host_wdata_i <= host_data_w'(row_data[i]);
        host_wr_en_i <= 1'b1;
        @(posedge clk);
        host_wr_en_i <= 1'b0;
        $display("done %s", row_name[i]);
      end
      k_iwr: begin
        i2c_addr_i  <= byte_w'(row_addr[i]);
        i2c_wdata_i <= byte_w'(row_data[i]);
        i2c_wr_en_i <= 1'b1;
        @(posedge clk);
        i2c_wr_en_i <= 1'b0;
        $display("done %s", row_name[i]);
      end
      k_hrd, k_hrd_done: begin
        host_raddr_i <= host_addr_w'(row_addr[i]);
        repeat (2) @(posedge clk);
        @(negedge clk);
        check_word(row_name[i], host_data_w'(row_exp[i]), host_rdata_o);
        if (row_kind[i] == k_hrd_done) begin
          @(posedge clk);
          host_rd_done_i <= 1'b1;  // address still held
          @(posedge clk);
          host_rd_done_i <= 1'b0;
        end
      end
      k_ird: begin
        i2c_addr_i <= byte_w'(row_addr[i]);
        repeat (2) @(posedge clk);
        @(negedge clk);
        check_byte(row_name[i], byte_w'(row_exp[i]), i2c_rdata_o);
      end
      k_irq: begin
        @(negedge clk);
        check_bit(row_name[i], row_exp[i][0], host_irq_o);
      end
      default: begin
        @(negedge clk);
        case (row_addr[i])
          0:       cfg_val = byte_w'(dev_addr_o);
          1:       cfg_val = byte_w'(enable_o);
          2:       cfg_val = debounce_len_o;
          3:       cfg_val = scl_delay_len_o;
          default: cfg_val = sda_delay_len_o;
        endcase
        check_byte(row_name[i], byte_w'(row_exp[i]), cfg_val);
      end
    endcase
  endtask

  initial begin
    int sva_fails;
    void'($urandom(32'h56b7));
    rst            = 1'b1;
    host_waddr_i   = '0;
    host_wdata_i   = '0;
    host_wr_en_i   = 1'b0;
    host_raddr_i   = '0;
    host_rd_done_i = 1'b0;
    i2c_addr_i     = '0;
    i2c_wdata_i    = '0;
    i2c_wr_en_i    = 1'b0;
    build_table();
    timeout_cycles = 16 + 8 * n_rows + 100;
    repeat (16) @(posedge clk);
    rst <= 1'b0;
    for (int i = 0; i < n_rows; i++) begin
      run_row(i);
    end
    sva_fails = UUT.u_sva.fail_count;
    $display("%0d rows, %0d checks passed, %0d failed, %0d assertion failures",
             n_rows, passes, errors, sva_fails);
    if (errors == 0 && sva_fails == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

// ==== sim/i2c_periph_regs_sva.sv ====
module i2c_periph_regs_sva
  import i2c_regs_pkg::*;
(
  input logic        clk,
  input logic        rst,
  input logic        fifo_push,
  input logic        fifo_pop,
  input fifo_flags_u fifo_flags,
  input logic [1:0]  irq_enable,
  input logic        host_irq_o
);
  timeunit 1ns;
  timeprecision 1ps;

  int unsigned fail_count = 0;

  // push into a full fifo must not move it, unless a pop goes at the same time
  full_push_dropped: assert property (@(posedge clk) disable iff (rst)
    (fifo_flags.bits.full && fifo_push && !fifo_pop) |=> fifo_flags.bits.full)
    else begin
      $error("fifo accepted a push while full");
      fail_count++;
    end

  irq_needs_enable: assert property (@(posedge clk) disable iff (rst)
    (irq_enable == 2'b00) |-> !host_irq_o)
    else begin
      $error("host interrupt high with interrupt enable cleared");
      fail_count++;
    end

  strobes_known: assert property (@(posedge clk) disable iff (rst)
    !$isunknown({fifo_push, fifo_pop}))
    else begin
      $error("fifo push or pop strobe is unknown");
      fail_count++;
    end

endmodule

bind i2c_periph_regs i2c_periph_regs_sva u_sva (
  .clk        (clk),
  .rst        (rst),
  .fifo_push  (fifo_push),
  .fifo_pop   (fifo_pop),
  .fifo_flags (fifo_flags),
  .irq_enable (u_host_port.irq_enable),
  .host_irq_o (host_irq_o)
);

// ==== hdl/i2c_periph_regs.sv ====
module i2c_periph_regs
  import i2c_regs_pkg::*;
(
  input  logic                   clk,
  input  logic                   rst,
  // host side
  input  logic [host_addr_w-1:0] host_waddr_i,
  input  logic [host_data_w-1:0] host_wdata_i,
  input  logic                   host_wr_en_i,
  input  logic [host_addr_w-1:0] host_raddr_i,
  input  logic                   host_rd_done_i,
  output logic [host_data_w-1:0] host_rdata_o,
  // i2c side
  input  logic [byte_w-1:0]      i2c_addr_i,
  input  logic [byte_w-1:0]      i2c_wdata_i,
  input  logic                   i2c_wr_en_i,
  output logic [byte_w-1:0]      i2c_rdata_o,
  // device configuration
  output logic [dev_addr_w-1:0]  dev_addr_o,
  output logic                   enable_o,
  output logic [byte_w-1:0]      debounce_len_o,
  output logic [byte_w-1:0]      scl_delay_len_o,
  output logic [byte_w-1:0]      sda_delay_len_o,
  output logic                   host_irq_o
);

  logic              fifo_push;
  logic [byte_w-1:0] fifo_wdata;
  logic              fifo_pop;
  logic [byte_w-1:0] fifo_rdata;
  fifo_flags_u       fifo_flags;
  logic              mbox_wr;
  logic [byte_w-1:0] mbox_wdata;
  logic [byte_w-1:0] mbox_data;
  logic              mbox_status;

  // producer
  i2c_reg_port u_i2c_port (
    .clk             (clk),
    .rst             (rst),
    .i2c_addr_i      (i2c_addr_i),
    .i2c_wdata_i     (i2c_wdata_i),
    .i2c_wr_en_i     (i2c_wr_en_i),
    .dev_addr_i      (dev_addr_o),
    .enable_i        (enable_o),
    .debounce_len_i  (debounce_len_o),
    .scl_delay_len_i (scl_delay_len_o),
    .sda_delay_len_i (sda_delay_len_o),
    .mbox_data_i     (mbox_data),
    .mbox_status_i   (mbox_status),
    .fifo_flags_i    (fifo_flags),
    .i2c_rdata_o     (i2c_rdata_o),
    .mbox_wr_o       (mbox_wr),
    .mbox_wdata_o    (mbox_wdata),
    .fifo_push_o     (fifo_push),
    .fifo_wdata_o    (fifo_wdata)
  );

  byte_fifo u_fifo (
    .clk     (clk),
    .rst     (rst),
    .push_i  (fifo_push),
    .wdata_i (fifo_wdata),
    .pop_i   (fifo_pop),
    .rdata_o (fifo_rdata),
    .flags_o (fifo_flags)
  );

  // consumer, also owns the config registers
  apb_reg_port u_host_port (
    .clk             (clk),
    .rst             (rst),
    .host_waddr_i    (host_waddr_i),
    .host_wdata_i    (host_wdata_i),
    .host_wr_en_i    (host_wr_en_i),
    .host_raddr_i    (host_raddr_i),
    .host_rd_done_i  (host_rd_done_i),
    .mbox_wr_i       (mbox_wr),
    .mbox_wdata_i    (mbox_wdata),
    .fifo_rdata_i    (fifo_rdata),
    .fifo_flags_i    (fifo_flags),
    .host_rdata_o    (host_rdata_o),
    .fifo_pop_o      (fifo_pop),
    .dev_addr_o      (dev_addr_o),
    .enable_o        (enable_o),
    .debounce_len_o  (debounce_len_o),
    .scl_delay_len_o (scl_delay_len_o),
    .sda_delay_len_o (sda_delay_len_o),
    .mbox_data_o     (mbox_data),
    .mbox_status_o   (mbox_status),
    .host_irq_o      (host_irq_o)
  );

endmodule

// ==== hdl/apb_reg_port.sv ====
module apb_reg_port
  import i2c_regs_pkg::*;
(
  input  logic                   clk,
  input  logic                   rst,
  input  logic [host_addr_w-1:0] host_waddr_i,
  input  logic [host_data_w-1:0] host_wdata_i,
  input  logic                   host_wr_en_i,
  input  logic [host_addr_w-1:0] host_raddr_i,
  input  logic                   host_rd_done_i,
  input  logic                   mbox_wr_i,
  input  logic [byte_w-1:0]      mbox_wdata_i,
  input  logic [byte_w-1:0]      fifo_rdata_i,
  input  fifo_flags_u            fifo_flags_i,
  output logic [host_data_w-1:0] host_rdata_o,
  output logic                   fifo_pop_o,
  output logic [dev_addr_w-1:0]  dev_addr_o,
  output logic                   enable_o,
  output logic [byte_w-1:0]      debounce_len_o,
  output logic [byte_w-1:0]      scl_delay_len_o,
  output logic [byte_w-1:0]      sda_delay_len_o,
  output logic [byte_w-1:0]      mbox_data_o,
  output logic                   mbox_status_o,
  output logic                   host_irq_o
);

  logic              wr_ok;
  logic              rd_ok;
  logic [byte_w-1:0] widx;
  logic [byte_w-1:0] ridx;
  logic [1:0]        irq_enable;
  logic [byte_w-1:0] irq_select;
  logic [1:0]        irq_status;
  fifo_flags_u       flags_q;
  logic [byte_w-1:0] rd_mux;

  // registers sit on 32-bit words, upper address bits must be zero
  assign widx  = host_waddr_i[byte_w+1:2];
  assign ridx  = host_raddr_i[byte_w+1:2];
  assign wr_ok = host_wr_en_i && (host_waddr_i[host_addr_w-1:byte_w+2] == '0);
  assign rd_ok = host_raddr_i[host_addr_w-1:byte_w+2] == '0;

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      dev_addr_o      <= def_dev_addr;
      enable_o        <= 1'b0;
      debounce_len_o  <= def_debounce_len;
      scl_delay_len_o <= def_scl_delay_len;
      sda_delay_len_o <= def_sda_delay_len;
      irq_enable      <= '0;
      irq_select      <= '0;
    end else if (wr_ok) begin
      case (widx)
        idx_dev_addr:   dev_addr_o      <= host_wdata_i[dev_addr_w-1:0];
        idx_enable:     enable_o        <= host_wdata_i[0];
        idx_debounce:   debounce_len_o  <= host_wdata_i[byte_w-1:0];
        idx_scl_delay:  scl_delay_len_o <= host_wdata_i[byte_w-1:0];
        idx_sda_delay:  sda_delay_len_o <= host_wdata_i[byte_w-1:0];
        idx_irq_enable: irq_enable      <= host_wdata_i[1:0];
        idx_irq_select: irq_select      <= host_wdata_i[byte_w-1:0];
        default: ;
      endcase
    end
  end

  // mailbox, fifo pop and flags snapshot
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      mbox_data_o   <= '0;
      mbox_status_o <= 1'b0;
      fifo_pop_o    <= 1'b0;
      flags_q       <= '0;
    end else begin
      if (mbox_wr_i) begin
        mbox_data_o <= mbox_wdata_i;
      end
      // a fresh write wins over a clear in the same cycle
      if (mbox_wr_i) begin
        mbox_status_o <= 1'b1;
      end else if (host_rd_done_i && rd_ok && ridx == idx_mbox_data) begin
        mbox_status_o <= 1'b0;
      end
      fifo_pop_o <= host_rd_done_i && rd_ok && (ridx == idx_fifo_rd);
      flags_q    <= fifo_flags_i;
    end
  end

  // select byte is indexed by the live flags code
  assign irq_status[1] = irq_enable[1] && irq_select[fifo_flags_i.code];
  assign irq_status[0] = irq_enable[0] && mbox_status_o;
  assign host_irq_o    = |irq_status;

  always_comb begin
    rd_mux = '0;
    if (rd_ok) begin
      case (ridx)
        idx_dev_addr:    rd_mux = byte_w'(dev_addr_o);
        idx_enable:      rd_mux = byte_w'(enable_o);
        idx_debounce:    rd_mux = debounce_len_o;
        idx_scl_delay:   rd_mux = scl_delay_len_o;
        idx_sda_delay:   rd_mux = sda_delay_len_o;
        idx_mbox_data:   rd_mux = mbox_data_o;
        idx_mbox_status: rd_mux = byte_w'(mbox_status_o);
        idx_fifo_rd:     rd_mux = fifo_rdata_i;  // head byte
        idx_fifo_flags:  rd_mux = byte_w'(flags_q.code);
        idx_irq_status:  rd_mux = byte_w'(irq_status);
        idx_irq_enable:  rd_mux = byte_w'(irq_enable);
        idx_irq_select:  rd_mux = irq_select;
        default:         rd_mux = '0;
      endcase
    end
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      host_rdata_o <= '0;
    end else begin
      host_rdata_o <= host_data_w'(rd_mux);
    end
  end

endmodule

// ==== hdl/byte_fifo.sv ====
module byte_fifo
  import i2c_regs_pkg::*;
(
  input  logic              clk,
  input  logic              rst,
  input  logic              push_i,
  input  logic [byte_w-1:0] wdata_i,
  input  logic              pop_i,
  output logic [byte_w-1:0] rdata_o,
  output fifo_flags_u       flags_o
);

  logic [byte_w-1:0]             mem [fifo_depth];
  logic [$clog2(fifo_depth)-1:0] wr_ptr;
  logic [$clog2(fifo_depth)-1:0] rd_ptr;  // wraps on its own, depth is 2^n
  logic [fifo_cnt_w-1:0]         count;
  logic                          push_ok;
  logic                          pop_ok;

  // full push dropped, empty pop ignored
  assign push_ok = push_i && !flags_o.bits.full;
  assign pop_ok  = pop_i && !flags_o.bits.empty;

  always_ff @(posedge clk) begin
    if (push_ok) begin
      mem[wr_ptr] <= wdata_i;
    end
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push_ok) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop_ok) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({push_ok, pop_ok})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;  // both or neither
      endcase
    end
  end

  assign rdata_o = mem[rd_ptr];  // show-ahead head byte

  always_comb begin
    flags_o.bits.full  = (count == fifo_cnt_w'(fifo_depth));
    flags_o.bits.half  = (count >= fifo_cnt_w'(fifo_depth / 2));
    flags_o.bits.empty = (count == '0);
  end

endmodule

// ==== hdl/i2c_reg_port.sv ====
module i2c_reg_port
  import i2c_regs_pkg::*;
(
  input  logic                  clk,
  input  logic                  rst,
  input  logic [byte_w-1:0]     i2c_addr_i,
  input  logic [byte_w-1:0]     i2c_wdata_i,
  input  logic                  i2c_wr_en_i,
  input  logic [dev_addr_w-1:0] dev_addr_i,
  input  logic                  enable_i,
  input  logic [byte_w-1:0]     debounce_len_i,
  input  logic [byte_w-1:0]     scl_delay_len_i,
  input  logic [byte_w-1:0]     sda_delay_len_i,
  input  logic [byte_w-1:0]     mbox_data_i,
  input  logic                  mbox_status_i,
  input  fifo_flags_u           fifo_flags_i,
  output logic [byte_w-1:0]     i2c_rdata_o,
  output logic                  mbox_wr_o,
  output logic [byte_w-1:0]     mbox_wdata_o,
  output logic                  fifo_push_o,
  output logic [byte_w-1:0]     fifo_wdata_o
);

  logic [byte_w-1:0] rd_mux;

  // mailbox is latched on the host side in this same edge
  assign mbox_wr_o    = i2c_wr_en_i && (i2c_addr_i == idx_mbox_data);
  assign mbox_wdata_o = i2c_wdata_i;

  // push strobe trails the i2c write by one cycle
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      fifo_push_o <= 1'b0;
    end else begin
      fifo_push_o <= i2c_wr_en_i && (i2c_addr_i == idx_fifo_wr);
    end
  end

  always_ff @(posedge clk) begin
    if (i2c_wr_en_i && (i2c_addr_i == idx_fifo_wr)) begin
      fifo_wdata_o <= i2c_wdata_i;
    end
  end

  always_comb begin
    case (i2c_addr_i)
      idx_dev_addr:    rd_mux = byte_w'(dev_addr_i);
      idx_enable:      rd_mux = byte_w'(enable_i);
      idx_debounce:    rd_mux = debounce_len_i;
      idx_scl_delay:   rd_mux = scl_delay_len_i;
      idx_sda_delay:   rd_mux = sda_delay_len_i;
      idx_mbox_data:   rd_mux = mbox_data_i;
      idx_mbox_status: rd_mux = byte_w'(mbox_status_i);
      idx_fifo_flags:  rd_mux = byte_w'(fifo_flags_i.code);
      default:         rd_mux = '0;  // unmapped reads as zero
    endcase
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      i2c_rdata_o <= '0;
    end else begin
      i2c_rdata_o <= rd_mux;
    end
  end

endmodule

// ==== hdl/i2c_regs_pkg.sv ====
package i2c_regs_pkg;

  // bus widths
  localparam int host_addr_w = 12;
  localparam int host_data_w = 32;
  localparam int byte_w      = 8;
  localparam int dev_addr_w  = 7;

  // i2c-to-host fifo
  localparam int fifo_depth = 16;
  localparam int fifo_cnt_w = 5;  // holds 0..fifo_depth

  // reset values of the device configuration
  localparam logic [dev_addr_w-1:0] def_dev_addr      = 7'h6f;
  localparam logic [byte_w-1:0]     def_debounce_len  = 8'd20;
  localparam logic [byte_w-1:0]     def_scl_delay_len = 8'd20;
  localparam logic [byte_w-1:0]     def_sda_delay_len = 8'd8;

  // register indices, host side uses addr[9:2]
  localparam logic [byte_w-1:0] idx_dev_addr    = 8'h00;
  localparam logic [byte_w-1:0] idx_enable      = 8'h01;
  localparam logic [byte_w-1:0] idx_debounce    = 8'h02;
  localparam logic [byte_w-1:0] idx_scl_delay   = 8'h03;
  localparam logic [byte_w-1:0] idx_sda_delay   = 8'h04;
  localparam logic [byte_w-1:0] idx_mbox_data   = 8'h10;
  localparam logic [byte_w-1:0] idx_mbox_status = 8'h11;
  localparam logic [byte_w-1:0] idx_fifo_wr     = 8'h20;  // i2c push port
  localparam logic [byte_w-1:0] idx_fifo_rd     = 8'h21;  // host pop port
  localparam logic [byte_w-1:0] idx_fifo_flags  = 8'h24;
  localparam logic [byte_w-1:0] idx_irq_status  = 8'h50;
  localparam logic [byte_w-1:0] idx_irq_enable  = 8'h51;
  localparam logic [byte_w-1:0] idx_irq_select  = 8'h53;

  // fifo flags: either a code into the irq select byte, or named bits
  typedef union packed {
    logic [2:0] code;
    struct packed {
      logic full;   // count == depth
      logic half;   // count >= depth/2
      logic empty;  // count == 0
    } bits;
  } fifo_flags_u;

endpackage
